// File: design/procPkg.sv
`default_nettype none

package procPkg;

  // Memory and register file sizes
  localparam int memDepth = 1024;
  localparam int memAddrWidth = $clog2(memDepth);
  localparam int regCount = 4;

  typedef logic [15:0] wordT;
  typedef logic [1:0] regSelT;
  typedef logic [memAddrWidth-1:0] memAddrT;

  // Codes 10 to 15 act as no-operations
  typedef enum logic [3:0] {
    opAdd = 4'd0,
    opSub = 4'd1,
    opLdr = 4'd2,
    opStr = 4'd3,
    opLda = 4'd4,
    opSta = 4'd5,
    opBz  = 4'd6,
    opJmp = 4'd7,
    opJr  = 4'd8,
    opCmp = 4'd9
  } opcodeT;

  // field8 doubles as rs2 in its top two bits
  typedef struct packed {
    logic [3:0] opcode;
    regSelT rd;
    regSelT rs1;
    logic [7:0] field8;
  } instrT;

  typedef enum logic {
    aluAdd = 1'b0,
    aluSub = 1'b1
  } aluOpT;

  // Top bit set means register target
  typedef enum logic [1:0] {
    pcIncrement = 2'b00,
    pcRelative  = 2'b01,
    pcRegister  = 2'b10
  } pcSelT;

endpackage

`default_nettype wire

// File: design/memoryArray.sv
`default_nettype none

module memoryArray #(
  parameter type payloadT = procPkg::wordT
) (
  input  logic             clk,
  input  logic             we,
  input  procPkg::memAddrT addr,
  input  payloadT          wdata,
  output payloadT          rdata
);

  import procPkg::*;

  // Storage, no reset
  payloadT mem [memDepth];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Asynchronous read
  assign rdata = mem[addr];

endmodule

`default_nettype wire

// File: design/registerFile.sv
`default_nettype none

module registerFile (
  input  logic            clk,
  input  logic            rst,
  input  logic            writeEn,
  input  procPkg::regSelT writeSel,
  input  procPkg::regSelT readSel1,
  input  procPkg::regSelT readSel2,
  input  procPkg::wordT   writeData,
  output procPkg::wordT   readData1,
  output procPkg::wordT   readData2
);

  import procPkg::*;

  wordT regs [regCount];

  // Single write port, all registers cleared on reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeSel] <= writeData;
    end
  end

  // Two independent read ports
  assign readData1 = regs[readSel1];
  assign readData2 = regs[readSel2];

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu (
  input  logic           clk,
  input  logic           rst,
  input  logic           flagEn,
  input  procPkg::aluOpT op,
  input  procPkg::wordT  in1,
  input  procPkg::wordT  in2,
  output procPkg::wordT  result,
  output logic           zFlag
);

  import procPkg::*;

  // Result wraps modulo 2^16
  always_comb begin
    if (op == aluSub) begin
      result = in1 - in2;
    end else begin
      result = in1 + in2;
    end
  end

  // Flag kept from the last flag-setting operation
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      zFlag <= 1'b0;
    end else if (flagEn) begin
      zFlag <= (result == '0);
    end
  end

endmodule

`default_nettype wire

// File: design/programCounter.sv
`default_nettype none

module programCounter (
  input  logic           clk,
  input  logic           rst,
  input  procPkg::pcSelT sel,
  input  procPkg::wordT  offset,
  input  procPkg::wordT  target,
  output procPkg::wordT  pc
);

  import procPkg::*;

  wordT nextPc;

  // Any code with the top bit set picks the register
  always_comb begin
    if (sel[1]) begin
      nextPc = target;
    end else if (sel == pcRelative) begin
      nextPc = pc + offset;
    end else begin
      nextPc = pc + 16'd1;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

endmodule

`default_nettype wire

// File: design/instructionDecoder.sv
`default_nettype none

module instructionDecoder (
  input  procPkg::instrT  instruction,
  input  logic            zFlag,
  output procPkg::pcSelT  pcSel,
  output logic            regWriteEn,
  output logic            flagEn,
  output logic            dataWe,
  output logic            dataAddrSel,
  output logic            regInSource,
  output procPkg::regSelT regWriteSel,
  output procPkg::regSelT readSel1,
  output procPkg::regSelT readSel2,
  output procPkg::aluOpT  aluOp,
  output procPkg::wordT   imm
);

  import procPkg::*;

  opcodeT opcode;

  assign opcode = opcodeT'(instruction.opcode);

  // Register fields are fixed in every format
  assign regWriteSel = instruction.rd;
  assign readSel1 = instruction.rs1;
  assign readSel2 = instruction.field8[7:6];

  // Branch offsets are signed, memory addresses are not
  always_comb begin
    if (opcode == opBz || opcode == opJmp) begin
      imm = {{8{instruction.field8[7]}}, instruction.field8};
    end else begin
      imm = {8'h00, instruction.field8};
    end
  end

  always_comb begin
    pcSel = pcIncrement;
    regWriteEn = 1'b0;
    flagEn = 1'b0;
    dataWe = 1'b0;
    dataAddrSel = 1'b0;
    regInSource = 1'b0;
    aluOp = aluAdd;

    case (opcode)
      opAdd: begin
        regWriteEn = 1'b1;
        flagEn = 1'b1;
      end
      opSub: begin
        regWriteEn = 1'b1;
        flagEn = 1'b1;
        aluOp = aluSub;
      end
      // Compare only updates the flag
      opCmp: begin
        flagEn = 1'b1;
        aluOp = aluSub;
      end
      // Register-indirect load and store
      opLdr: begin
        regWriteEn = 1'b1;
        regInSource = 1'b1;
        dataAddrSel = 1'b1;
      end
      opStr: begin
        dataWe = 1'b1;
        dataAddrSel = 1'b1;
      end
      // Absolute forms take the address from imm
      opLda: begin
        regWriteEn = 1'b1;
        regInSource = 1'b1;
      end
      opSta: begin
        dataWe = 1'b1;
      end
      opBz: begin
        pcSel = zFlag ? pcRelative : pcIncrement;
      end
      opJmp: begin
        pcSel = pcRelative;
      end
      opJr: begin
        pcSel = pcRegister;
      end
      default: begin
        // No-operation codes keep the defaults
        pcSel = pcIncrement;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/processor.sv
`default_nettype none

module processor (
  input  logic             clk,
  input  logic             rst,
  input  logic             loadWrite,
  input  logic             loadTarget,
  input  procPkg::memAddrT loadAddr,
  input  procPkg::wordT    loadData,
  output procPkg::wordT    pc,
  output logic             wbEn,
  output procPkg::regSelT  wbSel,
  output procPkg::wordT    wbData,
  output logic             memWe,
  output procPkg::memAddrT memAddr,
  output procPkg::wordT    memData
);

  import procPkg::*;

  instrT instruction;
  pcSelT pcSel;
  aluOpT aluOp;
  regSelT regWriteSel;
  regSelT readSel1;
  regSelT readSel2;
  wordT readData1;
  wordT readData2;
  wordT aluResult;
  wordT dataReadData;
  wordT imm;
  wordT dataAddrWord;
  wordT dataWdata;
  memAddrT instrAddr;
  memAddrT dataAddr;
  memAddrT dataMemAddr;
  logic regWriteEn;
  logic flagEn;
  logic dataWe;
  logic dataAddrSel;
  logic regInSource;
  logic zFlag;
  logic instrLoad;
  logic dataLoad;
  logic storeEn;

  // Load port steering, loadTarget 0 is instruction memory
  assign instrLoad = loadWrite && !loadTarget;
  assign dataLoad = loadWrite && loadTarget;

  // Program stores only outside reset, and a load wins over a store
  assign storeEn = dataWe && !rst && !dataLoad;

  assign instrAddr = instrLoad ? loadAddr : pc[memAddrWidth-1:0];

  memoryArray #(.payloadT(instrT)) instrMem (
    .clk(clk),
    .we(instrLoad),
    .addr(instrAddr),
    .wdata(instrT'(loadData)),
    .rdata(instruction)
  );

  // Data address from rs1 or the absolute field
  assign dataAddrWord = dataAddrSel ? readData1 : imm;
  assign dataAddr = dataAddrWord[memAddrWidth-1:0];
  assign dataMemAddr = dataLoad ? loadAddr : dataAddr;
  assign dataWdata = dataLoad ? loadData : readData2;

  memoryArray #(.payloadT(wordT)) dataMem (
    .clk(clk),
    .we(dataLoad || storeEn),
    .addr(dataMemAddr),
    .wdata(dataWdata),
    .rdata(dataReadData)
  );

  instructionDecoder decoder (
    .instruction(instruction),
    .zFlag(zFlag),
    .pcSel(pcSel),
    .regWriteEn(regWriteEn),
    .flagEn(flagEn),
    .dataWe(dataWe),
    .dataAddrSel(dataAddrSel),
    .regInSource(regInSource),
    .regWriteSel(regWriteSel),
    .readSel1(readSel1),
    .readSel2(readSel2),
    .aluOp(aluOp),
    .imm(imm)
  );

  registerFile regFile (
    .clk(clk),
    .rst(rst),
    .writeEn(regWriteEn),
    .writeSel(regWriteSel),
    .readSel1(readSel1),
    .readSel2(readSel2),
    .writeData(wbData),
    .readData1(readData1),
    .readData2(readData2)
  );

  alu aluUnit (
    .clk(clk),
    .rst(rst),
    .flagEn(flagEn),
    .op(aluOp),
    .in1(readData1),
    .in2(readData2),
    .result(aluResult),
    .zFlag(zFlag)
  );

  programCounter pcUnit (
    .clk(clk),
    .rst(rst),
    .sel(pcSel),
    .offset(imm),
    .target(readData1),
    .pc(pc)
  );

  // Writeback source, memory for loads
  assign wbData = regInSource ? dataReadData : aluResult;
  assign wbEn = regWriteEn;
  assign wbSel = regWriteSel;

  // Store observation
  assign memWe = storeEn;
  assign memAddr = dataAddr;
  assign memData = readData2;

endmodule

`default_nettype wire

// File: bench/processor_assertions.sv
`default_nettype none

module processor_assertions (
  input logic          clk,
  input logic          rst,
  input procPkg::wordT pc,
  input logic          wbEn,
  input logic          memWe
);

  timeunit 1ns;
  timeprecision 1ps;

  int failureCount = 0;

  // PC is cleared asynchronously, so it reads zero at every edge in reset
  pcZeroInReset: assert property (@(posedge clk) rst |-> pc == '0)
    else begin
      $error("pc is not zero while rst is high");
      failureCount++;
    end

  noStoreInReset: assert property (@(posedge clk) rst |-> !memWe)
    else begin
      $error("memWe is high while rst is high");
      failureCount++;
    end

  // No opcode both writes a register and stores
  oneWriteKind: assert property (@(posedge clk) !(wbEn && memWe))
    else begin
      $error("wbEn and memWe are high together");
      failureCount++;
    end

endmodule

bind processor processor_assertions assertionsInst (
  .clk(clk),
  .rst(rst),
  .pc(pc),
  .wbEn(wbEn),
  .memWe(memWe)
);

`default_nettype wire

// File: bench/processorTb.sv
`default_nettype none

module processorTb;

  timeunit 1ns;
  timeprecision 1ps;

  import procPkg::*;

  localparam int clkPeriod = 40;
  localparam int resetCycles = 3;
  localparam int loadCycles = 2 * memDepth;
  localparam int resetLength = 4;
  localparam int arithLength = 44;
  localparam int memoryLength = 64;
  localparam int controlLength = 40;
  localparam int randomLength = 400;
  // Each of the five tests reloads both memories
  localparam int totalCycles = 5 * (loadCycles + resetCycles + 2) + resetLength
    + arithLength + memoryLength + controlLength + randomLength;

  logic clk;
  logic rst;
  logic loadWrite;
  logic loadTarget;
  memAddrT loadAddr;
  wordT loadData;
  wordT pc;
  logic wbEn;
  regSelT wbSel;
  wordT wbData;
  logic memWe;
  memAddrT memAddr;
  wordT memData;

  // Reference model state
  instrT imem [memDepth];
  wordT dmem [memDepth];
  wordT regs [regCount];
  logic z;
  wordT modelPc;

  // Prediction for the instruction at modelPc
  logic expWbEn;
  regSelT expWbSel;
  wordT expWbData;
  logic expMemWe;
  memAddrT expMemAddr;
  wordT expMemData;

  string testName;
  int errorCount;
  int passCount;
  int failCount;
  int unsigned seedInit;

  processor DUT (
    .clk(clk),
    .rst(rst),
    .loadWrite(loadWrite),
    .loadTarget(loadTarget),
    .loadAddr(loadAddr),
    .loadData(loadData),
    .pc(pc),
    .wbEn(wbEn),
    .wbSel(wbSel),
    .wbData(wbData),
    .memWe(memWe),
    .memAddr(memAddr),
    .memData(memData)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(2 * totalCycles * clkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", 2 * totalCycles);
    $display("TEST FAILED");
    $finish;
  end

  task automatic checkWord(string what, wordT expected, wordT actual);
    if (actual !== expected) begin
      $display("error %s %s: expected %h, actual %h", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkSel(string what, regSelT expected, regSelT actual);
    if (actual !== expected) begin
      $display("error %s %s: expected %0d, actual %0d", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkAddr(string what, memAddrT expected, memAddrT actual);
    if (actual !== expected) begin
      $display("error %s %s: expected %h, actual %h", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  task automatic checkBit(string what, logic expected, logic actual);
    if (actual !== expected) begin
      $display("error %s %s: expected %b, actual %b", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  function automatic instrT encode(logic [3:0] op, regSelT rd, regSelT rs1, logic [7:0] field8);
    instrT instr;
    instr.opcode = op;
    instr.rd = rd;
    instr.rs1 = rs1;
    instr.field8 = field8;
    return instr;
  endfunction

  function automatic regSelT randomSel();
    return regSelT'($urandom_range(3, 0));
  endfunction

  // One instruction of the model, outputs compared before state moves on
  task automatic stepModel();
    instrT instr;
    wordT a;
    wordT b;
    wordT offset;
    wordT nextPc;
    logic nextZ;
    instr = imem[modelPc[memAddrWidth-1:0]];
    a = regs[instr.rs1];
    b = regs[instr.field8[7:6]];
    offset = {{8{instr.field8[7]}}, instr.field8};
    expWbEn = 1'b0;
    expWbSel = instr.rd;
    expWbData = '0;
    expMemWe = 1'b0;
    expMemAddr = '0;
    expMemData = b;
    nextPc = modelPc + 16'd1;
    nextZ = z;
    case (instr.opcode)
      opAdd, opSub, opCmp: begin
        expWbData = (instr.opcode == opAdd) ? a + b : a - b;
        expWbEn = (instr.opcode != opCmp);
        nextZ = (expWbData == 16'h0000);
      end
      opLdr: begin
        expWbEn = 1'b1;
        expWbData = dmem[a[memAddrWidth-1:0]];
      end
      opLda: begin
        expWbEn = 1'b1;
        expWbData = dmem[instr.field8];
      end
      opStr: begin
        expMemWe = 1'b1;
        expMemAddr = a[memAddrWidth-1:0];
      end
      opSta: begin
        expMemWe = 1'b1;
        expMemAddr = memAddrT'(instr.field8);
      end
      opBz: nextPc = z ? modelPc + offset : nextPc;
      opJmp: nextPc = modelPc + offset;
      opJr: nextPc = a;
      default: ;
    endcase
    checkWord("pc", modelPc, pc);
    checkBit("wbEn", expWbEn, wbEn);
    if (expWbEn) begin
      checkSel("wbSel", expWbSel, wbSel);
      checkWord("wbData", expWbData, wbData);
      regs[expWbSel] = expWbData;
    end
    checkBit("memWe", expMemWe, memWe);
    if (expMemWe) begin
      checkAddr("memAddr", expMemAddr, memAddr);
      checkWord("memData", expMemData, memData);
      dmem[expMemAddr] = expMemData;
    end
    z = nextZ;
    modelPc = nextPc;
  endtask

  // Reset stays high through the image load and three more cycles
  task automatic resetAndLoad();
    @(negedge clk);
    rst = 1'b1;
    for (int t = 0; t < 2; t++) begin
      for (int a = 0; a < memDepth; a++) begin
        loadWrite = 1'b1;
        loadTarget = t[0];
        loadAddr = memAddrT'(a);
        loadData = (t == 0) ? wordT'(imem[a]) : dmem[a];
        @(negedge clk);
      end
    end
    loadWrite = 1'b0;
    repeat (resetCycles) @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < regCount; r++) begin
      regs[r] = '0;
    end
    z = 1'b0;
    modelPc = '0;
  endtask

  task automatic runTest(string name, int cycles);
    int startErrors;
    testName = name;
    startErrors = errorCount;
    resetAndLoad();
    for (int i = 0; i < cycles; i++) begin
      // Sample a quarter period before the rising edge
      #(clkPeriod / 4);
      stepModel();
      @(negedge clk);
    end
    if (errorCount == startErrors) begin
      passCount++;
    end else begin
      failCount++;
    end
    $display("test %s finished with %0d mismatches", name, errorCount - startErrors);
  endtask

  task automatic fillDefault();
    for (int a = 0; a < memDepth; a++) begin
      // Opcode 15 is a no-operation, tagged with its address
      imem[a] = instrT'({4'hf, 2'b00, memAddrT'(a)});
      dmem[a] = wordT'($urandom());
    end
  endtask

  // Registers preloaded by LDA, then ALU or memory opcodes at random
  task automatic buildMixTest(int length, logic memoryMix);
    logic [3:0] op;
    logic [7:0] field8;
    int pick;
    fillDefault();
    if (memoryMix) begin
      // Small values keep register addresses colliding with absolute ones
      for (int a = 0; a < 256; a++) begin
        dmem[a] = wordT'($urandom_range(15, 0));
      end
    end
    for (int r = 0; r < regCount; r++) begin
      imem[r] = encode(opLda, regSelT'(r), 2'd0, 8'(r));
    end
    for (int i = regCount; i < length; i++) begin
      pick = $urandom_range(3, 0);
      if (memoryMix) begin
        op = 4'(opLdr) + 4'(pick);
        field8 = {randomSel(), 2'b00, 4'($urandom_range(15, 0))};
      end else begin
        op = (pick >= 2) ? 4'(opCmp) : 4'(pick);
        field8 = {randomSel(), 6'($urandom())};
      end
      imem[i] = encode(op, randomSel(), randomSel(), field8);
    end
  endtask

  // Loops through 1022 and 1023, then wraps into index 0
  task automatic buildControlTest();
    fillDefault();
    dmem[16] = 16'h0000;
    dmem[17] = 16'h03fe;
    imem[0] = encode(opLda, 2'd0, 2'd0, 8'h10);
    imem[1] = encode(opLda, 2'd1, 2'd0, 8'h11);
    imem[2] = encode(opCmp, 2'd0, 2'd0, 8'h00);
    imem[3] = encode(opBz, 2'd0, 2'd0, 8'd3);
    imem[6] = encode(opAdd, 2'd2, 2'd1, 8'h40);
    imem[7] = encode(opBz, 2'd0, 2'd0, 8'd5);
    imem[8] = encode(opJmp, 2'd0, 2'd0, 8'd4);
    imem[12] = encode(opJmp, 2'd0, 2'd0, 8'hfd);
    imem[9] = encode(opJr, 2'd0, 2'd1, 8'h00);
  endtask

  initial begin
    rst = 1'b1;
    loadWrite = 1'b0;
    loadTarget = 1'b0;
    loadAddr = '0;
    loadData = '0;
    errorCount = 0;
    passCount = 0;
    failCount = 0;
    seedInit = $urandom(32'h12e1_19e3);
    fillDefault();
    for (int r = 0; r < regCount; r++) begin
      imem[r] = encode(opLdr, regSelT'(r), 2'd3, 8'h00);
    end
    runTest("reset", resetLength);
    buildMixTest(arithLength, 1'b0);
    runTest("arithmetic", arithLength);
    buildMixTest(memoryLength, 1'b1);
    runTest("memory", memoryLength);
    buildControlTest();
    runTest("control", controlLength);
    for (int a = 0; a < memDepth; a++) begin
      imem[a] = instrT'($urandom());
      dmem[a] = wordT'($urandom());
    end
    runTest("random", randomLength);
    $display("tests passed %0d, failed %0d, assertion failures %0d",
      passCount, failCount, DUT.assertionsInst.failureCount);
    if (failCount == 0 && DUT.assertionsInst.failureCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
design/procPkg.sv
design/memoryArray.sv
design/registerFile.sv
design/alu.sv
design/programCounter.sv
design/instructionDecoder.sv
design/processor.sv
bench/processor_assertions.sv
bench/processorTb.sv

// File: Bender.yml
package:
  name: processor

sources:
  - design/procPkg.sv
  - design/memoryArray.sv
  - design/registerFile.sv
  - design/alu.sv
  - design/programCounter.sv
  - design/instructionDecoder.sv
  - design/processor.sv
  - target: test
    files:
      - bench/processor_assertions.sv
      - bench/processorTb.sv
